//--- common/rvFrontPkg.sv
`default_nettype none

package rvFrontPkg;

    localparam int xlen = 32;

    // rv32i major opcodes
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opAluImm = 7'b0010011;
    localparam logic [6:0] opAluReg = 7'b0110011;

    typedef enum logic [3:0] {
        clsAluReg,
        clsAluImm,
        clsLoad,
        clsStore,
        clsBranch,
        clsJal,
        clsJalr,
        clsLui,
        clsAuipc,
        clsIllegal
    } opClass;

    // format views, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFields;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFields;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFields;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFields;

    typedef struct packed {
        logic [19:0] imm; // bits 31..12 of the result
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFields;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFields;

    typedef union packed {
        rFields rType;
        iFields iType;
        sFields sType;
        bFields bType;
        uFields uType;
        jFields jType;
    } instrWord;

    localparam instrWord nopInstr = 32'h0000_0013; // addi x0,x0,0

    typedef struct packed {
        logic [xlen-1:0] pc;
        instrWord        instr;
    } fetchPacket;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        opClass          cls;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic            usesRs1;
        logic            usesRs2;
        logic            writesRd;
        logic [2:0]      funct3;
        logic [xlen-1:0] imm;    // already sign extended
    } decodedOp;

endpackage

`default_nettype wire

//--- rtl/instrMem.sv
`default_nettype none

module instrMem #(
    parameter int memDepth = 256
) (
    input  logic                              clk,
    input  logic                              loadEn,
    input  logic [$clog2(memDepth)-1:0]       loadAddr,
    input  logic [rvFrontPkg::xlen-1:0]       loadData,
    input  logic [$clog2(memDepth)-1:0]       readAddr,
    output rvFrontPkg::instrWord              readData
);
    import rvFrontPkg::*;

    logic [xlen-1:0] mem [memDepth]; // one word per entry

    // load port, only used before start
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    // registered read, word shows up one cycle after the address
    always_ff @(posedge clk) begin
        readData <= mem[readAddr];
    end

endmodule

`default_nettype wire

//--- fetch/pcGen.sv
`default_nettype none

module pcGen #(
    parameter int                          memDepth = 256,
    parameter logic [rvFrontPkg::xlen-1:0] resetPc  = '0
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          start,
    input  logic                          redirect,
    input  logic [rvFrontPkg::xlen-1:0]   redirectTarget,
    input  logic                          jalRedirect,
    input  logic [rvFrontPkg::xlen-1:0]   jalTarget,
    input  logic                          stall,
    input  rvFrontPkg::instrWord          readData,
    output logic [$clog2(memDepth)-1:0]   readAddr,
    output rvFrontPkg::fetchPacket        fetch,
    output logic                          fetchValid
);
    import rvFrontPkg::*;

    localparam int addrW = $clog2(memDepth);

    typedef enum logic {
        idle,
        running
    } pcState;

    pcState          state;
    logic [xlen-1:0] pc;        // next address to issue
    logic [xlen-1:0] issuedPc;  // pc of the word coming back from memory
    logic [xlen-1:0] issueAddr;
    logic            kill;

    // on stall, re-read the word that ifId could not take
    assign issueAddr = stall ? issuedPc : pc;
    assign readAddr  = issueAddr[addrW+1:2]; // word index, wraps at memDepth
    assign kill      = redirect || jalRedirect;

    assign fetch.pc    = issuedPc;
    assign fetch.instr = readData;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= idle;
            pc         <= resetPc;
            issuedPc   <= resetPc;
            fetchValid <= 1'b0;
        end else begin
            if (state == idle && start) begin
                state <= running; // first read goes out next cycle
            end
            issuedPc <= issueAddr;
            // valid tracks the read, dropped when a redirect kills it
            if (state != running || kill) begin
                fetchValid <= 1'b0;
            end else if (stall) begin
                fetchValid <= fetchValid; // re-read keeps its validity
            end else begin
                fetchValid <= 1'b1;
            end
            if (redirect) begin
                pc <= redirectTarget;  // later-stage branch wins
            end else if (jalRedirect) begin
                pc <= jalTarget;
            end else if (state == running && !stall) begin
                pc <= pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

//--- fetch/ifIdRegister.sv
`default_nettype none

module ifIdRegister (
    input  logic                   clk,
    input  logic                   rstN,
    input  rvFrontPkg::fetchPacket fetchIn,
    input  logic                   fetchValid,
    input  logic                   stall,
    input  logic                   flush,
    output rvFrontPkg::fetchPacket fetchOut,
    output logic                   outValid
);
    import rvFrontPkg::*;

    // stage holds a canonical nop whenever it is empty after reset or flush
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchOut.pc    <= '0;
            fetchOut.instr <= nopInstr;
            outValid       <= 1'b0;
        end else if (flush) begin
            // wrong-path word, replace with nop
            fetchOut.pc    <= '0;
            fetchOut.instr <= nopInstr;
            outValid       <= 1'b0;
        end else if (stall) begin
            fetchOut <= fetchOut; // decode retries the same word
            outValid <= outValid;
        end else if (fetchValid) begin
            fetchOut <= fetchIn;
            outValid <= 1'b1;
        end else begin
            outValid <= 1'b0; // no fetch this cycle, contents are stale
        end
    end

endmodule

`default_nettype wire

//--- decode/instrDecoder.sv
`default_nettype none

module instrDecoder (
    input  rvFrontPkg::fetchPacket        packet,
    input  logic                          packetValid,
    output rvFrontPkg::decodedOp          op,
    output logic                          jalRedirect,
    output logic [rvFrontPkg::xlen-1:0]   jalTarget
);
    import rvFrontPkg::*;

    instrWord        word;
    logic [xlen-1:0] iImm;
    logic [xlen-1:0] sImm;
    logic [xlen-1:0] bImm;
    logic [xlen-1:0] uImm;
    logic [xlen-1:0] jImm;
    logic            legalR;

    assign word = packet.instr;

    // immediates for every format, picked below by opcode
    assign iImm = {{20{word.iType.imm[11]}}, word.iType.imm};
    assign sImm = {{20{word.sType.immHi[6]}}, word.sType.immHi, word.sType.immLo};
    assign bImm = {{19{word.bType.imm12}}, word.bType.imm12, word.bType.imm11,
                   word.bType.imm10to5, word.bType.imm4to1, 1'b0};
    assign uImm = {word.uType.imm, 12'b0};
    assign jImm = {{11{word.jType.imm20}}, word.jType.imm20, word.jType.imm19to12,
                   word.jType.imm11, word.jType.imm10to1, 1'b0};

    // funct7 0100000 only for sub and sra
    assign legalR = (word.rType.funct7 == 7'b0000000) ||
                    (word.rType.funct7 == 7'b0100000 &&
                     (word.rType.funct3 == 3'b000 || word.rType.funct3 == 3'b101));

    always_comb begin
        op       = '0;
        op.valid = packetValid;
        op.pc    = packet.pc;
        op.cls   = clsIllegal;
        case (word.rType.opcode)
            opAluReg: begin
                op.cls     = legalR ? clsAluReg : clsIllegal;
                op.rd      = word.rType.rd;
                op.rs1     = word.rType.rs1;
                op.rs2     = word.rType.rs2;
                op.funct3  = word.rType.funct3;
                op.usesRs1 = 1'b1;
                op.usesRs2 = 1'b1;
                op.writesRd = 1'b1;
            end
            opAluImm, opLoad, opJalr: begin
                op.rd       = word.iType.rd;
                op.rs1      = word.iType.rs1;
                op.funct3   = word.iType.funct3;
                op.imm      = iImm;
                op.usesRs1  = 1'b1;
                op.writesRd = 1'b1;
                if (word.iType.opcode == opAluImm) begin
                    op.cls = clsAluImm;
                end else if (word.iType.opcode == opJalr) begin
                    op.cls = (word.iType.funct3 == 3'b000) ? clsJalr : clsIllegal;
                end else begin
                    // lb lh lw lbu lhu
                    op.cls = (word.iType.funct3 inside {3'b000, 3'b001, 3'b010,
                              3'b100, 3'b101}) ? clsLoad : clsIllegal;
                end
            end
            opStore: begin
                op.cls     = (word.sType.funct3 < 3'b011) ? clsStore : clsIllegal;
                op.rs1     = word.sType.rs1;
                op.rs2     = word.sType.rs2;
                op.funct3  = word.sType.funct3;
                op.imm     = sImm;
                op.usesRs1 = 1'b1;
                op.usesRs2 = 1'b1;
            end
            opBranch: begin
                // funct3 010 and 011 are unassigned
                op.cls     = (word.bType.funct3[2:1] == 2'b01) ? clsIllegal : clsBranch;
                op.rs1     = word.bType.rs1;
                op.rs2     = word.bType.rs2;
                op.funct3  = word.bType.funct3;
                op.imm     = bImm;
                op.usesRs1 = 1'b1;
                op.usesRs2 = 1'b1;
            end
            opLui, opAuipc: begin
                op.cls      = (word.uType.opcode == opLui) ? clsLui : clsAuipc;
                op.rd       = word.uType.rd;
                op.imm      = uImm;
                op.writesRd = 1'b1;
            end
            opJal: begin
                op.cls      = clsJal;
                op.rd       = word.jType.rd;
                op.imm      = jImm;
                op.writesRd = 1'b1;
            end
            default: op.cls = clsIllegal;
        endcase
        if (op.cls == clsIllegal) begin
            op.writesRd = 1'b0; // illegal ops never create a hazard
            op.usesRs1  = 1'b0;
            op.usesRs2  = 1'b0;
        end
    end

    // jal resolved here, target needs no register value
    assign jalRedirect = packetValid && (word.jType.opcode == opJal);
    assign jalTarget   = packet.pc + jImm;

endmodule

`default_nettype wire

//--- decode/hazardUnit.sv
`default_nettype none

module hazardUnit (
    input  rvFrontPkg::decodedOp idOp,
    input  rvFrontPkg::decodedOp exOp,
    output logic                 stall
);
    import rvFrontPkg::*;

    logic exIsLoad;
    logic rs1Hit;
    logic rs2Hit;

    // load in ex with a real destination, x0 never forwards anything
    assign exIsLoad = exOp.valid && (exOp.cls == clsLoad) &&
                      exOp.writesRd && (exOp.rd != 5'd0);

    assign rs1Hit = idOp.usesRs1 && (idOp.rs1 == exOp.rd);
    assign rs2Hit = idOp.usesRs2 && (idOp.rs2 == exOp.rd);

    // one bubble, the load leaves ex next cycle
    assign stall = idOp.valid && exIsLoad && (rs1Hit || rs2Hit);

endmodule

`default_nettype wire

//--- decode/idExRegister.sv
`default_nettype none

module idExRegister (
    input  logic                 clk,
    input  logic                 rstN,
    input  rvFrontPkg::decodedOp opIn,
    input  logic                 bubble,
    output rvFrontPkg::decodedOp opOut
);

    // bubble keeps the payload but marks the slot empty
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opOut <= '0;
        end else begin
            opOut <= opIn;
            if (bubble) begin
                opOut.valid <= 1'b0; // stall or killed by redirect
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/frontEndTop.sv
`default_nettype none

module frontEndTop #(
    parameter int                          memDepth = 256,
    parameter logic [rvFrontPkg::xlen-1:0] resetPc  = '0
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          start,
    input  logic                          redirect,
    input  logic [rvFrontPkg::xlen-1:0]   redirectTarget,
    input  logic                          loadEn,
    input  logic [$clog2(memDepth)-1:0]   loadAddr,
    input  logic [rvFrontPkg::xlen-1:0]   loadData,
    output rvFrontPkg::decodedOp          idExOp
);
    import rvFrontPkg::*;

    logic [$clog2(memDepth)-1:0] memAddr;
    instrWord                    memWord;
    fetchPacket                  fetchPkt;
    logic                        fetchValid;
    fetchPacket                  ifIdPkt;
    logic                        ifIdValid;
    decodedOp                    idOp;
    logic                        jalRedirect;
    logic [xlen-1:0]             jalTarget;
    logic                        stall;

    wire ifIdFlush = redirect || jalRedirect; // either redirect kills the word in IF/ID
    wire idExBubble = stall || redirect;      // jal itself still goes on

    instrMem #(.memDepth(memDepth)) mem0 (
        .clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .readAddr(memAddr), .readData(memWord)
    );

    pcGen #(.memDepth(memDepth), .resetPc(resetPc)) pcGen0 (
        .clk(clk), .rstN(rstN), .start(start),
        .redirect(redirect), .redirectTarget(redirectTarget),
        .jalRedirect(jalRedirect), .jalTarget(jalTarget), .stall(stall),
        .readData(memWord), .readAddr(memAddr),
        .fetch(fetchPkt), .fetchValid(fetchValid)
    );

    ifIdRegister ifId0 (
        .clk(clk), .rstN(rstN), .fetchIn(fetchPkt), .fetchValid(fetchValid),
        .stall(stall), .flush(ifIdFlush), .fetchOut(ifIdPkt), .outValid(ifIdValid)
    );

    instrDecoder dec0 (
        .packet(ifIdPkt), .packetValid(ifIdValid), .op(idOp),
        .jalRedirect(jalRedirect), .jalTarget(jalTarget)
    );

    hazardUnit hazard0 (
        .idOp(idOp), .exOp(idExOp), .stall(stall)
    );

    idExRegister idEx0 (
        .clk(clk), .rstN(rstN), .opIn(idOp), .bubble(idExBubble), .opOut(idExOp)
    );

endmodule

`default_nettype wire

//--- tests/frontEnd_sva.sv
`default_nettype none

module frontEndSva #(
    parameter bit checkNop = 1'b0 // only IF/ID turns into a nop
) (
    input logic        clk,
    input logic        rstN,
    input logic        kill,
    input logic        hold,
    input logic        validOut,
    input logic [31:0] wordOut
);

    killEmpties: assert property (@(posedge clk) disable iff (!rstN)
        kill |=> !validOut)
        else $error("stage still valid after flush or bubble");

    // addi x0,x0,0 after a flush
    nopOnKill: assert property (@(posedge clk) disable iff (!rstN)
        (checkNop && kill) |=> (wordOut == 32'h0000_0013))
        else $error("flushed stage does not hold the nop word");

    holdStable: assert property (@(posedge clk) disable iff (!rstN)
        hold |=> ($stable(validOut) && $stable(wordOut)))
        else $error("stage changed during stall");

endmodule

bind ifIdRegister frontEndSva #(.checkNop(1'b1)) ifIdSva0 (
    .clk(clk), .rstN(rstN), .kill(flush), .hold(stall && !flush),
    .validOut(outValid), .wordOut(fetchOut.instr)
);

bind idExRegister frontEndSva #(.checkNop(1'b0)) idExSva0 (
    .clk(clk), .rstN(rstN), .kill(bubble), .hold(1'b0),
    .validOut(opOut.valid), .wordOut(opOut.imm)
);

`default_nettype wire

//--- tests/frontEndChecker.sv
`default_nettype none

module frontEndChecker (
    input  logic                 clk,
    input  logic                 armed,       // test in progress
    input  logic                 started,     // start pulse already given
    input  logic [31:0]          testName,
    input  int                   expCount,
    input  logic [31:0]          expPc [64],
    input  logic [31:0]          expInfo [64], // cls in 11:8, rd in 4:0
    input  logic [31:0]          expImm [64],
    input  rvFrontPkg::decodedOp op,
    output logic                 testDone,
    output int                   passCount,
    output int                   failCount,
    output int                   errorCount
);
    import rvFrontPkg::*;

    int          idx;
    int          testErrors;
    int          passTotal = 0;
    int          failTotal = 0;
    int          errorTotal = 0;
    logic [31:0] gotInfo;

    assign gotInfo    = {20'd0, op.cls, 3'd0, op.rd};
    assign passCount  = passTotal;
    assign failCount  = failTotal;
    assign errorCount = errorTotal;

    // every valid slot is the next expected op and bubbles are skipped
    always @(posedge clk) begin
        if (!armed) begin
            idx        = 0;
            testErrors = 0;
            testDone   <= 1'b0;
        end else if (!testDone) begin
            if (!started && op.valid) begin
                $display("test %s: valid operation at pc %h before start",
                         testName, op.pc);
                testErrors++;
            end else if (op.valid) begin
                if (op.pc !== expPc[idx] || gotInfo !== expInfo[idx] ||
                    op.imm !== expImm[idx]) begin
                    $write("mismatch %s op %0d: expected pc %h info %h imm %h, ",
                           testName, idx, expPc[idx], expInfo[idx], expImm[idx]);
                    $display("got pc %h info %h imm %h", op.pc, gotInfo, op.imm);
                    testErrors++;
                end
                idx++;
                if (idx == expCount) begin
                    testDone   <= 1'b1;
                    errorTotal <= errorTotal + testErrors;
                    if (testErrors == 0) begin
                        passTotal <= passTotal + 1;
                        $display("test %s: passed, %0d operations", testName, expCount);
                    end else begin
                        failTotal <= failTotal + 1;
                        $display("test %s: failed, %0d errors", testName, testErrors);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/frontEndTb.sv
`default_nettype none

module frontEndTb;
    import rvFrontPkg::*;

    localparam int memDepth = 256;

    logic              clk = 1'b0;
    logic              rstN;
    logic              start;
    logic              redirect;
    logic [xlen-1:0]   redirectTarget;
    logic              loadEn;
    logic [7:0]        loadAddr;
    logic [xlen-1:0]   loadData;
    decodedOp          idExOp;

    logic [31:0] tv [512];    // raw test records
    logic [31:0] prog [64];
    logic [31:0] rPc [8];
    logic [31:0] rTgt [8];
    logic [31:0] expPc [64];
    logic [31:0] expInfo [64];
    logic [31:0] expImm [64];
    logic [31:0] testName;
    int          expCount;
    logic        armed;
    logic        started;
    logic        testDone;
    int          passCount;
    int          failCount;
    int          errorCount;

    int          ptr;
    int          nProg;
    int          nRedir;
    int          nTests;
    int          rIdx;
    int          cycles;
    int          limit;
    int          idle;
    bit          timedOut;

    frontEndTop #(.memDepth(memDepth), .resetPc(32'd0)) dut0 (
        .clk(clk), .rstN(rstN), .start(start), .redirect(redirect),
        .redirectTarget(redirectTarget), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .idExOp(idExOp)
    );

    frontEndChecker chk0 (
        .clk(clk), .armed(armed), .started(started), .testName(testName),
        .expCount(expCount), .expPc(expPc), .expInfo(expInfo), .expImm(expImm),
        .op(idExOp), .testDone(testDone), .passCount(passCount),
        .failCount(failCount), .errorCount(errorCount)
    );

    initial begin
        forever #20 clk = ~clk; // period 40
    end

    initial begin
        rstN           = 1'b0;
        start          = 1'b0;
        redirect       = 1'b0;
        redirectTarget = '0;
        loadEn         = 1'b0;
        loadAddr       = '0;
        loadData       = '0;
        armed          = 1'b0;
        started        = 1'b0;
        testName       = '0;
        expCount       = 0;
        nTests         = 0;
        timedOut       = 1'b0;
        void'($urandom(12497)); // one seed for the whole run
        $readmemh("tests/frontEndTests.txt", tv);
        ptr = 0;
        while (tv[ptr] !== 32'd0 && !timedOut) begin
            // unpack one record
            testName = tv[ptr];
            nProg    = int'(tv[ptr+1]);
            nRedir   = int'(tv[ptr+2]);
            expCount = int'(tv[ptr+3]);
            ptr      = ptr + 4;
            for (int i = 0; i < nProg; i++) begin
                prog[i] = tv[ptr+i];
            end
            ptr = ptr + nProg;
            for (int i = 0; i < nRedir; i++) begin
                rPc[i]  = tv[ptr+2*i];
                rTgt[i] = tv[ptr+2*i+1];
            end
            ptr = ptr + 2 * nRedir;
            for (int i = 0; i < expCount; i++) begin
                expPc[i]   = tv[ptr+3*i];
                expInfo[i] = tv[ptr+3*i+1];
                expImm[i]  = tv[ptr+3*i+2];
            end
            ptr = ptr + 3 * expCount;
            nTests++;

            // program words from address 0 then addi x0,x0,addr as filler
            for (int a = 0; a < memDepth; a++) begin
                @(posedge clk);
                armed    <= 1'b0;
                loadEn   <= 1'b1;
                loadAddr <= 8'(a);
                loadData <= (a < nProg) ? prog[a] : {12'(a), 20'h00013};
            end
            @(posedge clk);
            loadEn <= 1'b0;
            rstN   <= 1'b0;
            repeat (16) @(posedge clk);
            rstN    <= 1'b1;
            armed   <= 1'b1;
            started <= 1'b0;
            idle = int'($urandom % 8);
            repeat (idle + 1) @(posedge clk);
            start   <= 1'b1;
            started <= 1'b1;
            @(posedge clk);
            start <= 1'b0;

            cycles = 0;
            rIdx   = 0;
            limit  = 20 * expCount + 50;
            while (!testDone && !timedOut) begin
                @(posedge clk);
                redirect <= 1'b0;
                // marked op leaves decode this edge and redirect lands with it in ID/EX
                if (rIdx < nRedir && dut0.idOp.valid && !dut0.stall &&
                    dut0.idOp.pc == rPc[rIdx]) begin
                    redirect       <= 1'b1;
                    redirectTarget <= rTgt[rIdx];
                    rIdx++;
                end
                cycles++;
                if (cycles > limit) begin
                    $display("timeout: test %s did not deliver %0d operations in %0d cycles",
                             testName, expCount, limit);
                    timedOut = 1'b1;
                end
            end
            @(posedge clk);
            armed    <= 1'b0;
            redirect <= 1'b0;
        end

        $display("%0d tests, %0d passed, %0d failed, %0d errors", nTests, passCount,
                 failCount, errorCount);
        if (!timedOut && nTests > 0 && failCount == 0 && errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/frontEndTests.txt
// record: name (4 ascii chars), program words, redirect pairs, expected ops, then words
// prog words from pc 0; redirect pairs are pc at idExOp then target; ops are pc, cls<<8|rd, imm
666D7473 00000008 00000000 00000008
FFB00093 002081B3 0030A423 FE208EE3 123452B7 FFFFF317 FF012383 00408467
00000000 00000101 FFFFFFFB  00000004 00000003 00000000  00000008 00000300 00000008
0000000C 00000400 FFFFFFFC  00000010 00000705 12345000  00000014 00000806 FFFFF000
00000018 00000207 FFFFFFF0  0000001C 00000608 00000004
// jal forward over two words, then jal back to pc 0
6A756D70 00000006 00000000 00000006
00100093 00C000EF 00200113 00300193 00400213 FEDFF06F
00000000 00000101 00000001  00000004 00000501 0000000C  00000010 00000104 00000004
00000014 00000500 FFFFFFEC  00000000 00000101 00000001  00000004 00000501 0000000C
// external redirect at pc 8 to pc 0x20
72656472 0000000A 00000001 00000005
00100093 00200113 00300193 00400213 00500293 00800413 00900493 00A00513
00600313 00700393
00000008 00000020
00000000 00000101 00000001  00000004 00000102 00000002  00000008 00000103 00000003
00000020 00000106 00000006  00000024 00000107 00000007
// two load-use pairs, rs1 and rs2
6C647573 00000005 00000000 00000005
0000A283 00228333 00432383 00712023 00138413
00000000 00000205 00000000  00000004 00000006 00000000  00000008 00000207 00000004
0000000C 00000300 00000000  00000010 00000108 00000001
// end of records
00000000

//--- tb.f
common/rvFrontPkg.sv
rtl/instrMem.sv
fetch/pcGen.sv
fetch/ifIdRegister.sv
decode/instrDecoder.sv
decode/hazardUnit.sv
decode/idExRegister.sv
rtl/frontEndTop.sv
tests/frontEnd_sva.sv
tests/frontEndChecker.sv
tests/frontEndTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module frontEndTb -Mdir build
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./build/VfrontEndTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0
